/* testbench/photon_counter_vectors.txt */
# sel pulses sync lost pause
# sel = gate units, sync = source running, lost = expected report_sync_lost, pause = en low after
1 0 1 0 0
0 1 1 0 0
4 9 1 0 0
4 10 1 0 0
2 3 1 0 0
40 99 1 0 0
60 137 1 0 0
50 20 0 1 0
3 5 0 1 0
7 12 0 1 1
45 30 1 0 0
1 2 1 0 0
0 0 1 0 0
43 55 0 1 0
5 12 0 1 0
45 64 1 0 0
2 4 1 0 0
10 25 1 0 0

/* list.f */
src/photon_counter_pkg.sv
src/edge_detect.sv
src/interval_counter.sv
src/sync_monitor.sv
src/count_report.sv
src/photon_counter_top.sv
testbench/tb_photon_counter.sv

/* Makefile */
TOP = tb_photon_counter

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f list.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir

/* testbench/tb_photon_counter.sv */
`timescale 1ns/1ps

module tb_photon_counter;

    import photon_counter_pkg::*;

    // Vector columns
    localparam int MAX_VEC    = 64;
    localparam int COL_SEL    = 0;
    localparam int COL_PULSES = 1;
    localparam int COL_SYNC   = 2;
    localparam int COL_LOST   = 3;
    localparam int COL_PAUSE  = 4;

    // Two windows plus sync start delay and edge latency
    localparam int SETTLE_CLKS = 2 * SYNC_WINDOW_CLKS + 40;

    logic          clk;
    logic          rst_n;
    logic          en;
    logic          photon_pulse;
    logic          sync_in = 1'b0;
    interval_sel_t interval_sel;
    logic          data_update;
    bcd_count_t    count_bcd;
    single_count_t count_single;
    logic          count_overflow;
    logic          report_sync_lost;
    total_count_t  count_total;
    logic          ext_sync_lost;

    int           vec[MAX_VEC][5];
    int           n_vec;
    int           errors;
    int           tests_run;
    int           tests_failed;
    bit           aborted;
    int           cyc = 0;
    int           upd_cyc;
    int           settle = 0;
    int           sync_div = 0;
    logic         sync_run;
    logic         sync_run_q = 1'b0;
    logic         lost_prev;
    total_count_t exp_total;

    photon_counter_top u_dut (.*);

    always #2 clk = ~clk;

    ////////////////////////////////////////
    // Background sync source and monitor
    ////////////////////////////////////////

    // Cycle count, settle time since the last sync or enable change
    always @(posedge clk) begin
        cyc        <= cyc + 1;
        sync_run_q <= sync_run;
        if (!en || sync_run != sync_run_q) begin
            settle <= 0;
        end else if (settle < SETTLE_CLKS) begin
            settle <= settle + 1;
        end
    end

    // Mains sync stand-in, toggles every 20 clocks
    always @(negedge clk) begin
        if (!sync_run_q) begin
            sync_div <= 0;
        end else if (sync_div == 19) begin
            sync_div <= 0;
            sync_in  <= ~sync_in;
        end else begin
            sync_div <= sync_div + 1;
        end
    end

    // Once settled the flag must follow the source
    always @(negedge clk) begin
        if (settle == SETTLE_CLKS) begin
            assert (ext_sync_lost == !sync_run_q) else begin
                $display("error %0t: ext_sync_lost %0b with sync running %0b",
                         $time, ext_sync_lost, sync_run_q);
                errors++;
            end
        end
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    // Decimal digits, low digit in the low nibble
    function automatic bcd_count_t to_bcd(input int value);
        bcd_count_t digits;
        digits = '0;
        for (int d = 0; d < BCD_DIGITS; d++) begin
            digits[d*4 +: 4] = 4'(value % 10);
            value = value / 10;
        end
        return digits;
    endfunction

    // Zero selection is one unit
    function automatic int gate_clocks(input int sel);
        return (sel == 0 ? 1 : sel) * CLK_PER_UNIT;
    endfunction

    // Sync flag of the cycle before the update is kept in lost_prev
    task automatic wait_update(input int limit);
        int n;
        n = 0;
        lost_prev = ext_sync_lost;
        @(negedge clk);
        while (!data_update && n < limit) begin
            lost_prev = ext_sync_lost;
            @(negedge clk);
            n++;
        end
        if (!data_update) begin
            $display("timeout: no data_update within %0d clocks", limit);
            aborted = 1'b1;
        end
    endtask

    // Two clocks high, random gap of 2 to 5 clocks
    task automatic send_pulses(input int count);
        repeat (count) begin
            photon_pulse = 1'b1;
            repeat (2) @(negedge clk);
            photon_pulse = 1'b0;
            repeat (2 + $urandom % 4) @(negedge clk);
        end
    endtask

    // No update and blank outputs while en is low
    task automatic check_idle(input int clocks);
        repeat (clocks) begin
            @(negedge clk);
            assert (!data_update && count_single == '0 && count_bcd == '0 && !ext_sync_lost
                    && !report_sync_lost && count_total == exp_total) else begin
                $display("error %0t: output active or total changed with en low", $time);
                errors++;
            end
        end
    endtask

    // Enable, then one empty interval to align with the reports
    task automatic start_counting(input int next_sel);
        en = 1'b1;
        repeat (2) @(negedge clk);
        interval_sel = interval_sel_t'(next_sel);
        wait_update(256 * CLK_PER_UNIT);
        upd_cyc = cyc;
    endtask

    task automatic check_report(input int i);
        assert (count_single == single_count_t'(vec[i][COL_PULSES])) else begin
            $display("error %0t: count_single %0d, expected %0d",
                     $time, count_single, vec[i][COL_PULSES]);
            errors++;
        end
        assert (count_bcd == to_bcd(vec[i][COL_PULSES]) && !count_overflow) else begin
            $display("error %0t: count_bcd %h overflow %0b, expected %h",
                     $time, count_bcd, count_overflow, to_bcd(vec[i][COL_PULSES]));
            errors++;
        end
        assert (count_total == exp_total) else begin
            $display("error %0t: count_total %0d, expected %0d", $time, count_total, exp_total);
            errors++;
        end
        assert (cyc - upd_cyc == gate_clocks(vec[i][COL_SEL])) else begin
            $display("error %0t: update spacing %0d clocks, expected %0d",
                     $time, cyc - upd_cyc, gate_clocks(vec[i][COL_SEL]));
            errors++;
        end
        assert (report_sync_lost == lost_prev && report_sync_lost == (vec[i][COL_LOST] != 0))
        else begin
            $display("error %0t: report_sync_lost %0b, flag before update %0b, expected %0d",
                     $time, report_sync_lost, lost_prev, vec[i][COL_LOST]);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before && !aborted) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed", name);
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        int fd;
        int mark;
        logic [8*160-1:0] skip_line;
        clk          = 1'b0;
        rst_n        = 1'b0;
        en           = 1'b0;
        photon_pulse = 1'b0;
        interval_sel = '0;
        sync_run     = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        aborted      = 1'b0;
        exp_total    = '0;
        n_vec        = 0;
        void'($urandom(27));

        fd = $fopen("testbench/photon_counter_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/photon_counter_vectors.txt");
            aborted = 1'b1;
        end else begin
            // Lines that do not parse are comments
            while (!$feof(fd) && n_vec < MAX_VEC) begin
                if ($fscanf(fd, " %d %d %d %d %d", vec[n_vec][COL_SEL], vec[n_vec][COL_PULSES],
                            vec[n_vec][COL_SYNC], vec[n_vec][COL_LOST],
                            vec[n_vec][COL_PAUSE]) == 5) begin
                    n_vec++;
                end else begin
                    void'($fgets(skip_line, fd));
                end
            end
            $fclose(fd);
            if (n_vec == 0) begin
                $display("vector file holds no test lines");
                aborted = 1'b1;
            end
        end

        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        // Reset state, en still low for three intervals
        mark = errors;
        check_idle(3 * gate_clocks(0));
        report_test("reset_idle", mark);

        if (!aborted) begin
            start_counting(vec[0][COL_SEL]);
        end
        for (int i = 0; i < n_vec && !aborted; i++) begin
            mark = errors;
            sync_run = (vec[i][COL_SYNC] != 0);
            @(negedge clk);
            send_pulses(vec[i][COL_PULSES]);
            // Mid-interval change, takes effect from the next interval
            if (i + 1 < n_vec) begin
                interval_sel = interval_sel_t'(vec[i+1][COL_SEL]);
            end
            wait_update(gate_clocks(vec[i][COL_SEL]) + 8);
            if (!aborted) begin
                exp_total = exp_total + total_count_t'(vec[i][COL_PULSES]);
                check_report(i);
                upd_cyc = cyc;
            end
            report_test($sformatf("vector %0d", i), mark);
            if (!aborted && vec[i][COL_PAUSE] != 0) begin
                mark = errors;
                en = 1'b0;
                check_idle(3 * gate_clocks(int'(interval_sel)));
                report_test("en_low_hold", mark);
                start_counting(int'(interval_sel));
            end
        end

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (!aborted && errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* src/photon_counter_top.sv */
`timescale 1ns/1ps

module photon_counter_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              en,
    input  logic                              photon_pulse,
    input  logic                              sync_in,
    input  photon_counter_pkg::interval_sel_t interval_sel,
    output logic                              data_update,
    output photon_counter_pkg::bcd_count_t    count_bcd,
    output photon_counter_pkg::single_count_t count_single,
    output logic                              count_overflow,
    output logic                              report_sync_lost,
    output photon_counter_pkg::total_count_t  count_total,
    output logic                              ext_sync_lost
);

    import photon_counter_pkg::*;

    // Edge strobes
    logic pulse_rise;
    logic sync_rise;

    // Interval results towards the report block
    logic          interval_done;
    bcd_count_t    interval_bcd;
    single_count_t interval_single;
    logic          interval_overflow;

    ////////////////////////////////////////
    // Front end edge detection
    ////////////////////////////////////////

    // Photon input, only rising edges are counted
    edge_detect u_pulse_edge (
        .clk    (clk),
        .rst_n  (rst_n),
        .en     (en),
        .sig_in (photon_pulse),
        .rise   (pulse_rise),
        .fall   ()
    );

    // Mains sync input
    edge_detect u_sync_edge (
        .clk    (clk),
        .rst_n  (rst_n),
        .en     (en),
        .sig_in (sync_in),
        .rise   (sync_rise),
        .fall   ()
    );

    ////////////////////////////////////////
    // Counting and monitoring
    ////////////////////////////////////////

    interval_counter u_interval_counter (
        .clk               (clk),
        .rst_n             (rst_n),
        .en                (en),
        .pulse_rise        (pulse_rise),
        .interval_sel      (interval_sel),
        .interval_done     (interval_done),
        .interval_bcd      (interval_bcd),
        .interval_single   (interval_single),
        .interval_overflow (interval_overflow)
    );

    // Sync state goes out directly and into the report
    sync_monitor u_sync_monitor (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .sync_rise (sync_rise),
        .sync_lost (ext_sync_lost)
    );

    count_report u_count_report (
        .clk               (clk),
        .rst_n             (rst_n),
        .en                (en),
        .interval_done     (interval_done),
        .interval_bcd      (interval_bcd),
        .interval_single   (interval_single),
        .interval_overflow (interval_overflow),
        .sync_lost         (ext_sync_lost),
        .data_update       (data_update),
        .count_bcd         (count_bcd),
        .count_single      (count_single),
        .count_overflow    (count_overflow),
        .report_sync_lost  (report_sync_lost),
        .count_total       (count_total)
    );

endmodule

/* src/count_report.sv */
`timescale 1ns/1ps

module count_report (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              en,
    input  logic                              interval_done,
    input  photon_counter_pkg::bcd_count_t    interval_bcd,
    input  photon_counter_pkg::single_count_t interval_single,
    input  logic                              interval_overflow,
    input  logic                              sync_lost,
    output logic                              data_update,
    output photon_counter_pkg::bcd_count_t    count_bcd,
    output photon_counter_pkg::single_count_t count_single,
    output logic                              count_overflow,
    output logic                              report_sync_lost,
    output photon_counter_pkg::total_count_t  count_total
);

    import photon_counter_pkg::*;

    ////////////////////////////////////////
    // Interval report
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_update      <= 1'b0;
            count_bcd        <= '0;
            count_single     <= '0;
            count_overflow   <= 1'b0;
            report_sync_lost <= 1'b0;
        end else if (!en) begin
            // Displayed values blank while disabled
            data_update      <= 1'b0;
            count_bcd        <= '0;
            count_single     <= '0;
            count_overflow   <= 1'b0;
            report_sync_lost <= 1'b0;
        end else begin
            data_update <= interval_done;
            // Hold last report until the next interval end
            if (interval_done) begin
                count_bcd        <= interval_bcd;
                count_single     <= interval_single;
                count_overflow   <= interval_overflow;
                report_sync_lost <= sync_lost;
            end
        end
    end

    ////////////////////////////////////////
    // Running total
    ////////////////////////////////////////

    // Only rst_n clears it, wraps silently
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_total <= '0;
        end else if (en && interval_done) begin
            count_total <= count_total + total_count_t'(interval_single);
        end
    end

endmodule

/* src/sync_monitor.sv */
`timescale 1ns/1ps

module sync_monitor (
    input  logic clk,
    input  logic rst_n,
    input  logic en,
    input  logic sync_rise,
    output logic sync_lost
);

    import photon_counter_pkg::*;

    ////////////////////////////////////////
    // Window timing
    ////////////////////////////////////////

    logic [$clog2(SYNC_WINDOW_CLKS)-1:0] win_cnt;
    logic                                win_end;

    assign win_end = (win_cnt == ($clog2(SYNC_WINDOW_CLKS))'(SYNC_WINDOW_CLKS - 1));

    ////////////////////////////////////////
    // Edge tally
    ////////////////////////////////////////

    sync_cnt_t sync_cnt;
    logic      saw_edge;

    // Edge in the last window cycle still belongs to this window
    assign saw_edge = (sync_cnt != '0) || sync_rise;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_cnt   <= '0;
            sync_cnt  <= '0;
            sync_lost <= 1'b0;
        end else if (!en) begin
            win_cnt   <= '0;
            sync_cnt  <= '0;
            sync_lost <= 1'b0;
        end else if (win_end) begin
            // Decision lands one clock after window end
            win_cnt   <= '0;
            sync_cnt  <= '0;
            sync_lost <= !saw_edge;
        end else begin
            win_cnt <= win_cnt + 1'b1;
            // Saturating tally where only zero versus nonzero matters
            if (sync_rise && (sync_cnt != '1)) begin
                sync_cnt <= sync_cnt + 1'b1;
            end
        end
    end

    // Flag moves only after a window end, or drops while disabled
    a_lost_changes_at_window_end: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(sync_lost) |-> ($past(en) ? $past(win_end) : !sync_lost));

endmodule

/* src/interval_counter.sv */
`timescale 1ns/1ps

module interval_counter (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              en,
    input  logic                              pulse_rise,
    input  photon_counter_pkg::interval_sel_t interval_sel,
    output logic                              interval_done,
    output photon_counter_pkg::bcd_count_t    interval_bcd,
    output photon_counter_pkg::single_count_t interval_single,
    output logic                              interval_overflow
);

    import photon_counter_pkg::*;

    ////////////////////////////////////////
    // Gate timer
    ////////////////////////////////////////

    logic          start_q;
    interval_sel_t sel_q;
    interval_sel_t sel_eff;
    unit_cnt_t     unit_cnt;
    interval_sel_t unit_num;
    logic          unit_end;

    // New selection only taken in the first cycle of an interval
    // Zero selection behaves as one unit
    assign sel_eff = !start_q ? sel_q :
                     (interval_sel == '0) ? interval_sel_t'(1) : interval_sel;

    assign unit_end      = (unit_cnt == unit_cnt_t'(CLK_PER_UNIT - 1));
    assign interval_done = en && unit_end && (unit_num == interval_sel_t'(sel_eff - 1'b1));

    ////////////////////////////////////////
    // Photon counters
    ////////////////////////////////////////

    bcd_count_t    bcd_q;
    bcd_count_t    bcd_next;
    logic          bcd_full;
    logic          ovf_q;
    single_count_t single_q;
    single_count_t single_next;
    logic          carry;
    logic [3:0]    digit;

    // Display range exhausted, hold at all nines
    assign bcd_full = (bcd_q == {BCD_DIGITS{BCD_MAX_DIGIT}});

    // Ripple decimal carry through the digits
    always_comb begin
        carry = pulse_rise && !bcd_full;
        for (int i = 0; i < BCD_DIGITS; i++) begin
            digit = bcd_q[i*4 +: 4];
            if (carry) begin
                if (digit == BCD_MAX_DIGIT) begin
                    digit = 4'd0;
                end else begin
                    digit = digit + 4'd1;
                    carry = 1'b0;
                end
            end
            bcd_next[i*4 +: 4] = digit;
        end
    end

    // Binary count saturates at all ones
    assign single_next = (pulse_rise && (single_q != '1)) ? single_q + 1'b1 : single_q;

    // Results include a pulse landing in the done cycle
    assign interval_bcd      = bcd_next;
    assign interval_single   = single_next;
    assign interval_overflow = ovf_q | (pulse_rise & bcd_full);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_q  <= 1'b1;
            sel_q    <= '0;
            unit_cnt <= '0;
            unit_num <= '0;
            bcd_q    <= '0;
            single_q <= '0;
            ovf_q    <= 1'b0;
        end else if (!en) begin
            // First enabled cycle opens a fresh interval
            start_q  <= 1'b1;
            sel_q    <= '0;
            unit_cnt <= '0;
            unit_num <= '0;
            bcd_q    <= '0;
            single_q <= '0;
            ovf_q    <= 1'b0;
        end else begin
            start_q <= interval_done;
            sel_q   <= sel_eff;
            if (interval_done) begin
                // Restart from zero next cycle
                unit_cnt <= '0;
                unit_num <= '0;
                bcd_q    <= '0;
                single_q <= '0;
                ovf_q    <= 1'b0;
            end else begin
                unit_cnt <= unit_end ? '0 : unit_cnt + 1'b1;
                unit_num <= unit_end ? unit_num + 1'b1 : unit_num;
                bcd_q    <= bcd_next;
                single_q <= single_next;
                ovf_q    <= interval_overflow;
            end
        end
    end

    for (genvar g = 0; g < BCD_DIGITS; g++) begin : g_digit_chk
        a_digit_range: assert property (@(posedge clk) disable iff (!rst_n)
            bcd_q[g*4 +: 4] <= BCD_MAX_DIGIT);
    end

    a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
        interval_done |=> !interval_done);

endmodule

/* src/edge_detect.sv */
`timescale 1ns/1ps

module edge_detect (
    input  logic clk,
    input  logic rst_n,
    input  logic en,
    input  logic sig_in,
    output logic rise,
    output logic fall
);

    // Two-flop synchronizer then previous value for compare
    logic sync_ff1;
    logic sync_ff2;
    logic sig_prev;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_ff1 <= 1'b0;
            sync_ff2 <= 1'b0;
            sig_prev <= 1'b0;
            rise     <= 1'b0;
            fall     <= 1'b0;
        end else if (!en) begin
            // History cleared so no stale edge after re-enable
            sync_ff1 <= 1'b0;
            sync_ff2 <= 1'b0;
            sig_prev <= 1'b0;
            rise     <= 1'b0;
            fall     <= 1'b0;
        end else begin
            sync_ff1 <= sig_in;
            sync_ff2 <= sync_ff1;
            sig_prev <= sync_ff2;
            // Registered strobes three clocks after the input edge
            rise     <= sync_ff2 & ~sig_prev;
            fall     <= ~sync_ff2 & sig_prev;
        end
    end

    // Strobe direction matches the input level three clocks back
    a_edge_matches_input: assert property (@(posedge clk) disable iff (!rst_n)
        (rise || fall) |-> (rise != fall) && (rise == $past(sig_in, 3)));

endmodule

/* src/photon_counter_pkg.sv */
package photon_counter_pkg;

    ////////////////////////////////////////
    // Time bases
    ////////////////////////////////////////

    // Clocks in one gate time unit
    // Scaled down for simulation
    localparam logic [31:0] CLK_PER_UNIT = 32'd20;

    // Length of one sync check window in clocks
    localparam logic [31:0] SYNC_WINDOW_CLKS = 32'd400;

    ////////////////////////////////////////
    // BCD display format
    ////////////////////////////////////////

    // Digits shown on the display
    localparam int BCD_DIGITS = 8;

    // Largest value a single decimal digit may hold
    localparam logic [3:0] BCD_MAX_DIGIT = 4'd9;

    ////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////

    // Eight packed BCD digits
    // Least significant digit in bits 3:0
    typedef logic [31:0] bcd_count_t;

    // Binary photon count of one interval, saturating
    typedef logic [15:0] single_count_t;

    // Running binary total, wraps at 2^32
    typedef logic [31:0] total_count_t;

    // Gate time selection in units, 0 read as 1
    typedef logic [7:0] interval_sel_t;

    // Clock counter inside one gate unit
    typedef logic [15:0] unit_cnt_t;

    // Sync edges seen in one window
    typedef logic [7:0] sync_cnt_t;

endpackage
